// File: hdl/usb_ctrl_pkg.sv
package usb_ctrl_pkg;

	// one byte of the FTDI stream
	typedef logic [7:0] byte_t;

	// address byte that follows the frame header
	typedef logic [7:0] reg_addr_t;

	localparam reg_addr_t SYS_TIME_REG_ADDR = 8'h00;
	localparam reg_addr_t SDI_CTRL_REG_ADDR = 8'h08;
	localparam reg_addr_t CSI_CTRL_REG_ADDR = 8'h0a;
	localparam reg_addr_t CCW_BUF_ADDR      = 8'h0c;

	// longest register, in bytes
	localparam int MAX_REG_BYTES = 8;

	// one-hot position of the current data byte
	typedef logic [MAX_REG_BYTES-1:0] byte_en_t;

	// system time register contents, byte 0 at the top
	typedef logic [63:0] st_bytes_t;

	// running time snapshot from the time counter
	typedef struct packed {
		logic [15:0] day;
		logic [26:0] ms_of_day;
		logic [9:0]  us_of_ms;
	} sys_time_t;

	typedef enum logic [1:0] {
		FRM_CTRL,
		FRM_ADDR,
		FRM_DATA
	} frame_state_t;

	// write bus from the frame decoder to every target
	typedef struct packed {
		byte_t    data;
		byte_en_t byte_en;
		logic     last;
	} reg_wr_t;

	// bit 0 STR, bit 1 SDI, bit 2 CSI, bit 3 CCW
	typedef logic [3:0] reg_sel_t;

endpackage

// File: hdl/usb_frame_decoder.sv
`timescale 1ns/10ps

module usb_frame_decoder (
	input  logic                   clk_ftdi,
	input  logic                   n_rst,
	input  usb_ctrl_pkg::byte_t    d,
	input  logic                   d_asserted,
	output usb_ctrl_pkg::reg_wr_t  wr,
	output usb_ctrl_pkg::reg_sel_t sel
);

	import usb_ctrl_pkg::*;

	frame_state_t state;
	reg_addr_t    addr_q;
	byte_en_t     byte_en_q;
	logic         data_cycle;
	logic         frame_end;

	// header, address, then data while d_asserted holds
	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			state <= FRM_CTRL;
		else
		begin
			case (state)
				FRM_CTRL:
					if (d_asserted)
						state <= FRM_ADDR;
				FRM_ADDR:
					state <= FRM_DATA;
				FRM_DATA:
					if (!d_asserted)
						state <= FRM_CTRL;
				default:
					state <= FRM_CTRL;
			endcase
		end
	end

	assign data_cycle = (state == FRM_DATA) && d_asserted;
	// first cycle with the marker low after data
	assign frame_end  = (state == FRM_DATA) && !d_asserted;

	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			addr_q <= '0;
		else if (state == FRM_ADDR)
			addr_q <= d;
	end

	// one-hot byte position, runs out to zero after 8 data bytes
	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			byte_en_q <= '0;
		else if (state == FRM_ADDR)
			byte_en_q <= byte_en_t'(1);
		else if (data_cycle)
			byte_en_q <= byte_en_q << 1;
	end

	assign wr.data    = d;
	assign wr.byte_en = data_cycle ? byte_en_q : '0;
	assign wr.last    = frame_end;

	// target select, kept through the last cycle
	always_comb
	begin
		sel = '0;
		if (state == FRM_DATA)
		begin
			case (addr_q)
				SYS_TIME_REG_ADDR: sel[0] = 1'b1;
				SDI_CTRL_REG_ADDR: sel[1] = 1'b1;
				CSI_CTRL_REG_ADDR: sel[2] = 1'b1;
				CCW_BUF_ADDR:      sel[3] = 1'b1;
				default:           sel = '0;
			endcase
		end
	end

endmodule

// File: hdl/sys_time_reg.sv
`timescale 1ns/10ps

module sys_time_reg (
	input  logic                    clk_ftdi,
	input  logic                    n_rst,
	input  usb_ctrl_pkg::reg_wr_t   wr,
	input  logic                    sel_en,
	input  logic                    tim_wrreq,
	input  usb_ctrl_pkg::sys_time_t st_time,
	output usb_ctrl_pkg::st_bytes_t q,
	output logic                    st_preset
);

	import usb_ctrl_pkg::*;

	st_bytes_t snap;

	// day in bytes 0-1, ms in 2-5, us in 6-7
	assign snap = {
		st_time.day,
		5'd0,
		st_time.ms_of_day,
		6'd0,
		st_time.us_of_ms
	};

	// snapshot load wins over a usb byte
	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			q <= '0;
		else if (tim_wrreq)
			q <= snap;
		else if (sel_en)
		begin
			for (int i = 0; i < MAX_REG_BYTES; i++)
			begin
				if (wr.byte_en[i])
					q[(MAX_REG_BYTES-1-i)*8 +: 8] <= wr.data;
			end
		end
	end

	// time counter loads q on this strobe
	assign st_preset = sel_en & wr.last;

endmodule

// File: hdl/ctrl_reg.sv
`timescale 1ns/10ps

module ctrl_reg #(
	parameter int NUM_BYTES = 2
) (
	input  logic                   clk_ftdi,
	input  logic                   n_rst,
	input  usb_ctrl_pkg::reg_wr_t  wr,
	input  logic                   sel_en,
	output logic [NUM_BYTES*8-1:0] q
);

	// lane 0 sits at the top of q
	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			q <= '0;
		else if (sel_en)
		begin
			for (int i = 0; i < NUM_BYTES; i++)
			begin
				if (wr.byte_en[i])
					q[(NUM_BYTES-1-i)*8 +: 8] <= wr.data;
			end
		end
	end

endmodule

// File: hdl/ccw_buf.sv
`timescale 1ns/10ps

module ccw_buf #(
	parameter int ADDR_BITS = 6
) (
	input  logic                  clk_ftdi,
	input  logic                  n_rst,
	input  usb_ctrl_pkg::reg_wr_t wr,
	input  logic                  sel_en,
	input  logic                  rdreq,
	output usb_ctrl_pkg::byte_t   q,
	output logic                  buf_is_read,
	output logic                  ccw_accepted
);

	import usb_ctrl_pkg::*;

	byte_t                mem [0:2**ADDR_BITS-1];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	// stored byte count, one bit wider for the +2
	logic [ADDR_BITS:0]   len_q;
	logic                 wr_en;
	logic                 last_rd;
	logic                 buf_is_read_d;
	logic                 rearm;

	// data cycles of a ccw frame, not the trailing last cycle
	assign wr_en = sel_en & ~wr.last;

	assign ccw_accepted = sel_en & wr.last;

	always_ff @(posedge clk_ftdi)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr.data;
	end

	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			wr_ptr <= '0;
		else if (rearm)
			wr_ptr <= '0;
		else if (wr_en)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// data byte 1 carries the message length
	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			len_q <= '0;
		else if (wr_en && (wr_ptr == ADDR_BITS'(1)))
			len_q <= {1'b0, wr.data[ADDR_BITS-1:0]} + 2'd2;
	end

	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			rd_ptr <= '0;
		else if (rearm)
			rd_ptr <= '0;
		else if (rdreq)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// registered read data, held between requests
	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
			q <= '0;
		else if (rdreq)
			q <= mem[rd_ptr];
	end

	assign last_rd = ({1'b0, rd_ptr} == len_q - 1'b1);

	always_ff @(posedge clk_ftdi or negedge n_rst)
	begin
		if (!n_rst)
		begin
			buf_is_read   <= 1'b0;
			buf_is_read_d <= 1'b0;
		end
		else
		begin
			buf_is_read   <= rdreq & last_rd;
			buf_is_read_d <= buf_is_read;
		end
	end

	// falling edge of buf_is_read clears both pointers
	assign rearm = buf_is_read_d & ~buf_is_read;

endmodule

// File: hdl/usb_ctrl_regs.sv
`timescale 1ns/10ps

module usb_ctrl_regs #(
	parameter int CCW_ADDR_BITS = 6,
	parameter int SDI_BYTES     = 2,
	parameter int CSI_BYTES     = 3
) (
	input  logic                    clk_ftdi,
	input  logic                    n_rst,
	input  usb_ctrl_pkg::byte_t     d,
	input  logic                    d_asserted,
	input  usb_ctrl_pkg::sys_time_t st_time,
	input  logic                    st_tim_100ms_wrreq,
	input  logic                    ccwb_rdreq,
	output logic [SDI_BYTES*8-1:0]  sdi_bytes,
	output logic [CSI_BYTES*8-1:0]  csi_bytes,
	output usb_ctrl_pkg::st_bytes_t st_bytes,
	output logic                    st_preset,
	output usb_ctrl_pkg::byte_t     ccw_byte,
	output logic                    ccw_accepted,
	output logic                    ccwb_is_read
);

	import usb_ctrl_pkg::*;

	reg_wr_t  wr;
	reg_sel_t sel;

	usb_frame_decoder i_frame_decoder (
		.clk_ftdi   (clk_ftdi),
		.n_rst      (n_rst),
		.d          (d),
		.d_asserted (d_asserted),
		.wr         (wr),
		.sel        (sel)
	);

	sys_time_reg i_str (
		.clk_ftdi  (clk_ftdi),
		.n_rst     (n_rst),
		.wr        (wr),
		.sel_en    (sel[0]),
		.tim_wrreq (st_tim_100ms_wrreq),
		.st_time   (st_time),
		.q         (st_bytes),
		.st_preset (st_preset)
	);

	ctrl_reg #(.NUM_BYTES(SDI_BYTES)) i_sdi_cr (
		.clk_ftdi (clk_ftdi),
		.n_rst    (n_rst),
		.wr       (wr),
		.sel_en   (sel[1]),
		.q        (sdi_bytes)
	);

	ctrl_reg #(.NUM_BYTES(CSI_BYTES)) i_csi_cr (
		.clk_ftdi (clk_ftdi),
		.n_rst    (n_rst),
		.wr       (wr),
		.sel_en   (sel[2]),
		.q        (csi_bytes)
	);

	ccw_buf #(.ADDR_BITS(CCW_ADDR_BITS)) i_ccw_buf (
		.clk_ftdi     (clk_ftdi),
		.n_rst        (n_rst),
		.wr           (wr),
		.sel_en       (sel[3]),
		.rdreq        (ccwb_rdreq),
		.q            (ccw_byte),
		.buf_is_read  (ccwb_is_read),
		.ccw_accepted (ccw_accepted)
	);

endmodule

// File: testbench/tb_usb_ctrl_regs.sv
`timescale 1ns/10ps

module tb_usb_ctrl_regs;

	import usb_ctrl_pkg::*;

	localparam int CLK_PERIOD = 8;
	// 20 us, far longer than all tests together
	localparam int TIMEOUT_CYCLES = 2500;

	logic        clk_ftdi = 1'b0;
	logic        n_rst;
	logic        d_asserted;
	logic        st_tim_100ms_wrreq;
	logic        ccwb_rdreq;
	byte_t       d;
	byte_t       ccw_byte;
	sys_time_t   st_time;
	sys_time_t   snap_t;
	logic [15:0] sdi_bytes;
	logic [15:0] sdi_exp;
	logic [23:0] csi_bytes;
	logic [23:0] csi_exp;
	st_bytes_t   st_bytes;
	st_bytes_t   st_exp;
	logic        st_preset;
	logic        ccw_accepted;
	logic        ccwb_is_read;
	// model of the one-cycle strobes
	logic        preset_exp;
	logic        accept_exp;
	logic        is_read_exp;
	logic [31:0] lfsr_q;
	byte_t       fdata [0:15];
	int          fail_count;
	int          test_mark;
	int          tests_passed;
	int          tests_failed;

	usb_ctrl_regs i_usb_ctrl_regs (.*);

	always #(CLK_PERIOD/2) clk_ftdi = ~clk_ftdi;

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [63:0] next_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		assert (got === exp)
		else
		begin
			fail_count++;
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = fail_count - test_mark;
		test_mark = fail_count;
		if (errs == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test %s finished with %0d errors", name, errs);
	endtask

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++)
			fdata[i] = byte_t'(next_bits(8));
	endtask

	// header, address, n data bytes, then marker low for last and one idle cycle
	task automatic send_frame(input byte_t addr, input int n);
		@(posedge clk_ftdi);
		d <= 8'h5a;
		d_asserted <= 1'b1;
		@(posedge clk_ftdi);
		d <= addr;
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk_ftdi);
			d <= fdata[i];
		end
		@(posedge clk_ftdi);
		d <= '0;
		d_asserted <= 1'b0;
		preset_exp <= (addr == SYS_TIME_REG_ADDR);
		accept_exp <= (addr == CCW_BUF_ADDR);
		@(posedge clk_ftdi);
		preset_exp <= 1'b0;
		accept_exp <= 1'b0;
	endtask

	// stores len+2 bytes, then reads them back one request every other cycle
	task automatic ccw_round_trip(input int len);
		int n;
		n = len + 2;
		fill_random(n);
		fdata[1] = {fdata[1][7:6], 6'(len)};
		send_frame(CCW_BUF_ADDR, n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk_ftdi);
			ccwb_rdreq <= 1'b1;
			is_read_exp <= 1'b0;
			@(posedge clk_ftdi);
			ccwb_rdreq <= 1'b0;
			is_read_exp <= (i == n - 1);
			@(negedge clk_ftdi);
			check_value(64'(ccw_byte), 64'(fdata[i]), "ccw_byte");
		end
		@(posedge clk_ftdi);
		is_read_exp <= 1'b0;
		// give the pointers time to rearm
		repeat (2) @(posedge clk_ftdi);
	endtask

	always @(negedge clk_ftdi)
	begin
		check_value(64'(st_preset), 64'(preset_exp), "st_preset");
		check_value(64'(ccw_accepted), 64'(accept_exp), "ccw_accepted");
		check_value(64'(ccwb_is_read), 64'(is_read_exp), "ccwb_is_read");
	end

	initial
	begin
		#(CLK_PERIOD * TIMEOUT_CYCLES);
		$display("timeout: the tests did not complete in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		n_rst = 1'b0;
		d = '0;
		d_asserted = 1'b0;
		st_time = '0;
		st_tim_100ms_wrreq = 1'b0;
		ccwb_rdreq = 1'b0;
		preset_exp = 1'b0;
		accept_exp = 1'b0;
		is_read_exp = 1'b0;
		lfsr_q = 32'h5066;
		fail_count = 0;
		test_mark = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (8) @(posedge clk_ftdi);
		n_rst <= 1'b1;
		@(negedge clk_ftdi);
		check_value(64'(sdi_bytes), 64'd0, "sdi_bytes after reset");
		check_value(64'(csi_bytes), 64'd0, "csi_bytes after reset");
		check_value(st_bytes, 64'd0, "st_bytes after reset");
		check_value(64'(ccw_byte), 64'd0, "ccw_byte after reset");
		end_test("reset");

		// third sdi byte has no lane
		fill_random(3);
		send_frame(SDI_CTRL_REG_ADDR, 3);
		sdi_exp = {fdata[0], fdata[1]};
		fill_random(3);
		send_frame(CSI_CTRL_REG_ADDR, 3);
		csi_exp = {fdata[0], fdata[1], fdata[2]};
		fill_random(3);
		send_frame(8'h20, 3);
		@(negedge clk_ftdi);
		check_value(64'(sdi_bytes), 64'(sdi_exp), "sdi_bytes");
		check_value(64'(csi_bytes), 64'(csi_exp), "csi_bytes");
		check_value(st_bytes, 64'd0, "st_bytes after unused address");
		end_test("sdi_csi_write");

		fill_random(8);
		send_frame(SYS_TIME_REG_ADDR, 8);
		st_exp = {fdata[0], fdata[1], fdata[2], fdata[3], fdata[4], fdata[5], fdata[6], fdata[7]};
		@(negedge clk_ftdi);
		check_value(st_bytes, st_exp, "st_bytes after usb write");
		end_test("str_write");

		snap_t = sys_time_t'(next_bits(53));
		@(posedge clk_ftdi);
		st_time <= snap_t;
		st_tim_100ms_wrreq <= 1'b1;
		@(posedge clk_ftdi);
		st_tim_100ms_wrreq <= 1'b0;
		@(negedge clk_ftdi);
		st_exp = {snap_t.day, 32'(snap_t.ms_of_day), 16'(snap_t.us_of_ms)};
		check_value(st_bytes, st_exp, "st_bytes after snapshot");
		end_test("time_snapshot");

		ccw_round_trip(5);
		ccw_round_trip(11);
		end_test("ccw_round_trip");

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: all.f
hdl/usb_ctrl_pkg.sv
hdl/usb_frame_decoder.sv
hdl/sys_time_reg.sv
hdl/ctrl_reg.sv
hdl/ccw_buf.sv
hdl/usb_ctrl_regs.sv
testbench/tb_usb_ctrl_regs.sv
